//--- compile.f
verilog/pin_test_pkg.sv
verilog/axi_lite_reg_bridge.sv
verilog/pin_test_regs.sv
verilog/pin_probe_sequencer.sv
verilog/static_pin_tester.sv
testbench/tb_static_pin_tester.sv

//--- Makefile
# Verilator simulation of the static pin tester

VERILATOR ?= verilator
TOP       ?= tb_static_pin_tester
FILELIST  ?= compile.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/tb_static_pin_tester.sv
module tb_static_pin_tester import pin_test_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WIDTH         = 8;
	localparam int SETTLE_CYCLES = 6;
	localparam int ADDR_WIDTH    = 11;
	localparam int WORD_BITS     = ADDR_WIDTH - 2;
	localparam int CLK_PERIOD    = 100;
	localparam int RESET_CYCLES  = 16;
	localparam int SYNC_WAIT     = 6;  // Well past the 2-cycle synchronizer
	localparam int N_MANUAL      = 10;
	localparam int N_STROBE      = 8;
	localparam int N_BAD         = 6;
	localparam int N_PROBES      = 3;
	localparam int POLL_LIMIT    = 4 * SETTLE_CYCLES;
	localparam int N_TXN         = 220;  // Rough count of AXI transfers in the run
	localparam int TXN_CYCLES    = 10;
	localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + N_PROBES * 4 * SETTLE_CYCLES
		+ N_TXN * TXN_CYCLES + (N_MANUAL + 4 * N_PROBES) * SYNC_WAIT);
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic                  clk;
	logic                  rst_n;
	logic [ADDR_WIDTH-1:0] s_axi_awaddr;
	logic                  s_axi_awvalid;
	logic                  s_axi_awready;
	logic [31:0]           s_axi_wdata;
	logic [3:0]            s_axi_wstrb;
	logic                  s_axi_wvalid;
	logic                  s_axi_wready;
	logic [1:0]            s_axi_bresp;
	logic                  s_axi_bvalid;
	logic                  s_axi_bready;
	logic [ADDR_WIDTH-1:0] s_axi_araddr;
	logic                  s_axi_arvalid;
	logic                  s_axi_arready;
	logic [31:0]           s_axi_rdata;
	logic [1:0]            s_axi_rresp;
	logic                  s_axi_rvalid;
	logic                  s_axi_rready;
	logic [WIDTH-1:0]      pad_o;
	logic [WIDTH-1:0]      pad_t;
	logic [WIDTH-1:0]      pad_i;

	logic [WIDTH-1:0] tie_gnd;         // Board connection per pin
	logic [WIDTH-1:0] tie_vcc;
	logic [WIDTH-1:0] keeper = '0;     // Last level driven onto each pin
	logic [WIDTH-1:0] ref_drive;
	logic [WIDTH-1:0] ref_tristate;
	logic [WIDTH-1:0] ref_keeper;
	logic [31:0]      lfsr = 32'hfece;
	int               drive_cycles = 0;
	int               checks = 0;
	int               errors = 0;

	static_pin_tester #(
		.WIDTH(WIDTH),
		.SETTLE_CYCLES(SETTLE_CYCLES),
		.ADDR_WIDTH(ADDR_WIDTH)
	) DUT (
		.s_axi_aclk(clk),
		.*
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Floating pins show the driven level, or the keeper when released
	assign pad_i = tie_vcc | (~tie_gnd & ~tie_vcc & ((pad_t & keeper) | (~pad_t & pad_o)));

	always @(negedge clk) begin
		for (int i = 0; i < WIDTH; i++) begin
			if (pad_t[i] == 1'b0)
				keeper[i] <= pad_o[i];
		end
		if (pad_t == '0)
			drive_cycles <= drive_cycles + 1;  // Probe drive phases
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] reg_addr(input int index);
		return ADDR_WIDTH'(index * 4);
	endfunction

	function automatic logic [WIDTH-1:0] expected_read();
		logic [WIDTH-1:0] val;
		for (int i = 0; i < WIDTH; i++) begin
			if (tie_gnd[i])
				val[i] = 1'b0;
			else if (tie_vcc[i])
				val[i] = 1'b1;
			else
				val[i] = ref_tristate[i] ? ref_keeper[i] : ref_drive[i];
		end
		return val;
	endfunction

	function automatic logic [2*WIDTH-1:0] expected_class();
		logic [2*WIDTH-1:0] cls;
		for (int i = 0; i < WIDTH; i++) begin
			if (tie_gnd[i])
				cls[2*i +: 2] = PIN_GND;
			else if (tie_vcc[i])
				cls[2*i +: 2] = PIN_VCC;
			else
				cls[2*i +: 2] = PIN_FLOAT;  // Keeper follows both drives
		end
		return cls;
	endfunction

	task automatic axi_write(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int delay;
		@(posedge clk);
		s_axi_awaddr  <= addr;
		s_axi_awvalid <= 1'b1;
		s_axi_wdata   <= data;
		s_axi_wstrb   <= strb;
		s_axi_wvalid  <= 1'b1;
		@(negedge clk);
		while (!s_axi_awready)
			@(negedge clk);
		checks++;
		if (!s_axi_wready) begin
			errors++;
			$display("Write data was not accepted together with the write address");
		end
		@(posedge clk);  // Handshake edge
		s_axi_awvalid <= 1'b0;
		s_axi_wvalid  <= 1'b0;
		delay = int'(rand_bits(2));
		repeat (delay) @(posedge clk);
		s_axi_bready <= 1'b1;
		@(negedge clk);
		while (!s_axi_bvalid)
			@(negedge clk);
		resp = s_axi_bresp;
		@(posedge clk);
		s_axi_bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [ADDR_WIDTH-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int delay;
		@(posedge clk);
		s_axi_araddr  <= addr;
		s_axi_arvalid <= 1'b1;
		@(negedge clk);
		while (!s_axi_arready)
			@(negedge clk);
		@(posedge clk);
		s_axi_arvalid <= 1'b0;
		delay = int'(rand_bits(2));  // Hold rvalid for a while
		repeat (delay) @(posedge clk);
		s_axi_rready <= 1'b1;
		@(negedge clk);
		while (!s_axi_rvalid)
			@(negedge clk);
		data = s_axi_rdata;
		resp = s_axi_rresp;
		@(posedge clk);
		s_axi_rready <= 1'b0;
	endtask

	task automatic write_reg(input int index, input logic [31:0] data, input logic [3:0] strb);
		logic [1:0] resp;
		axi_write(reg_addr(index), data, strb, resp);
		checks++;
		if (resp != RESP_OKAY) begin
			errors++;
			$display("[FAIL] %0d ns: write to index %0d answered %b, expected OKAY",
				$time, index, resp);
		end
	endtask

	task automatic expect_reg(input int index, input logic [31:0] exp, input string name);
		logic [31:0] data;
		logic [1:0]  resp;
		axi_read(reg_addr(index), data, resp);
		checks++;
		if (resp != RESP_OKAY || data != exp) begin
			errors++;
			$display("[FAIL] %0d ns: %s read 0x%08h resp %b, expected 0x%08h OKAY",
				$time, name, data, resp, exp);
		end
	endtask

	task automatic update_keeper();
		ref_keeper = (ref_keeper & ref_tristate) | (ref_drive & ~ref_tristate);
	endtask

	task automatic randomize_pins();
		logic [WIDTH-1:0] gnd;
		logic [WIDTH-1:0] vcc;
		logic [1:0]       kind;
		for (int i = 0; i < WIDTH; i++) begin
			kind   = 2'(rand_bits(2));
			gnd[i] = (kind == 2'd0);
			vcc[i] = (kind == 2'd1);  // Codes 2 and 3 float
		end
		@(posedge clk);
		tie_gnd <= gnd;
		tie_vcc <= vcc;
	endtask

	task automatic manual_round();
		logic [WIDTH-1:0] drive;
		logic [WIDTH-1:0] tristate;
		drive    = WIDTH'(rand_bits(WIDTH));
		tristate = WIDTH'(rand_bits(WIDTH));
		randomize_pins();
		write_reg(REG_DRIVE, 32'(drive), 4'hf);
		ref_drive = drive;
		update_keeper();
		write_reg(REG_TRISTATE, 32'(tristate), 4'hf);
		ref_tristate = tristate;
		update_keeper();
		repeat (SYNC_WAIT) @(posedge clk);
		expect_reg(REG_READ, 32'(expected_read()), "pad value");
	endtask

	task automatic strobe_test();
		logic [31:0] data;
		logic [3:0]  strb;
		for (int n = 0; n < N_STROBE; n++) begin
			data = rand_bits(32);
			strb = 4'(rand_bits(4));
			write_reg(REG_DRIVE, data, strb);
			if (strb[0])
				ref_drive = data[WIDTH-1:0];  // Pins sit in byte 0
			update_keeper();
			expect_reg(REG_DRIVE, 32'(ref_drive), "strobed drive");
		end
		write_reg(REG_READ, rand_bits(32), 4'hf);
		write_reg(REG_WIDTH, rand_bits(32), 4'hf);
		write_reg(REG_STATUS, rand_bits(32), 4'hf);
		repeat (SYNC_WAIT) @(posedge clk);
		expect_reg(REG_READ, 32'(expected_read()), "pad value after write");
		expect_reg(REG_WIDTH, 32'(WIDTH), "width after write");
		expect_reg(REG_STATUS, 32'h0, "status after write");
		expect_reg(REG_TRISTATE, 32'(ref_tristate), "tristate after write");
	endtask

	task automatic bad_index_test();
		logic [WORD_BITS-1:0]  word;
		logic [ADDR_WIDTH-1:0] addr;
		logic [31:0]           data;
		logic [1:0]            resp;
		for (int n = 0; n < N_BAD; n++) begin
			word = (n == 0) ? WORD_BITS'(N_REG) : WORD_BITS'(rand_bits(WORD_BITS));
			if (word < WORD_BITS'(N_REG))
				word = word + WORD_BITS'(N_REG);
			addr = {word, 2'b00};
			axi_read(addr, data, resp);
			checks++;
			if (resp != RESP_SLVERR || data != 32'h0) begin
				errors++;
				$display("[FAIL] %0d ns: read of index %0d gave 0x%08h resp %b, expected 0 SLVERR",
					$time, word, data, resp);
			end
			axi_write(addr, rand_bits(32), 4'hf, resp);
			checks++;
			if (resp != RESP_SLVERR) begin
				errors++;
				$display("[FAIL] %0d ns: write to index %0d answered %b, expected SLVERR",
					$time, word, resp);
			end
			expect_reg(REG_DRIVE, 32'(ref_drive), "drive after bad write");
			expect_reg(REG_TRISTATE, 32'(ref_tristate), "tristate after bad write");
			expect_reg(REG_STATUS, 32'h0, "status after bad write");  // No probe started
		end
	endtask

	task automatic run_probe();
		logic [31:0] status;
		logic [1:0]  resp;
		int          polls;
		int          drive_start;
		randomize_pins();
		write_reg(REG_TRISTATE, 32'({WIDTH{1'b1}}), 4'hf);  // Only probe phases drive
		ref_tristate = '1;
		drive_start  = drive_cycles;
		write_reg(REG_CTRL, 32'h1, 4'h1);
		expect_reg(REG_STATUS, 32'h1, "status while busy");
		write_reg(REG_CTRL, 32'h1, 4'hf);  // Start again while busy
		polls  = 0;
		status = '0;
		while (status[1:0] != 2'b10 && polls < POLL_LIMIT) begin
			axi_read(reg_addr(REG_STATUS), status, resp);
			polls++;
		end
		checks++;
		if (status[1:0] != 2'b10) begin
			errors++;
			$display("Probe did not report done within %0d status reads", POLL_LIMIT);
		end
		ref_keeper = '1;  // Last probe drive was 1
		expect_reg(REG_CLASS, 32'(expected_class()), "pin class");
		expect_reg(REG_STATUS, 32'h2, "status after probe");
		checks++;
		if (drive_cycles - drive_start != 2 * SETTLE_CYCLES) begin
			errors++;
			$display("[FAIL] %0d ns: probe drove pins for %0d cycles, expected %0d",
				$time, drive_cycles - drive_start, 2 * SETTLE_CYCLES);
		end
	endtask

	initial begin
		rst_n         = 1'b0;
		s_axi_awaddr  = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wstrb   = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b0;
		s_axi_araddr  = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b0;
		tie_gnd       = '1;
		tie_vcc       = '0;
		ref_drive     = '0;
		ref_tristate  = '1;
		ref_keeper    = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		expect_reg(REG_DRIVE, 32'h0, "drive after reset");
		expect_reg(REG_TRISTATE, 32'({WIDTH{1'b1}}), "tristate after reset");
		expect_reg(REG_STATUS, 32'h0, "status after reset");
		expect_reg(REG_CLASS, 32'h0, "class after reset");
		expect_reg(REG_WIDTH, 32'(WIDTH), "width");
		expect_reg(REG_CTRL, 32'h0, "control");

		repeat (N_MANUAL) manual_round();
		strobe_test();
		bad_index_test();
		repeat (N_PROBES) begin
			run_probe();
			repeat (4) manual_round();  // Pads back under manual control
		end

		$display("Run finished with %0d checks and %0d errors", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- verilog/static_pin_tester.sv
module static_pin_tester import pin_test_pkg::*; #(
		parameter int WIDTH         = 8,
		parameter int SETTLE_CYCLES = 16,
		parameter int ADDR_WIDTH    = 11
	) (
		input  logic                          s_axi_aclk,
		input  logic                          rst_n,

		input  logic [ADDR_WIDTH-1:0]         s_axi_awaddr,
		input  logic                          s_axi_awvalid,
		output logic                          s_axi_awready,
		input  logic [AXI_DATA_WIDTH-1:0]     s_axi_wdata,
		input  logic [AXI_DATA_WIDTH/8-1:0]   s_axi_wstrb,
		input  logic                          s_axi_wvalid,
		output logic                          s_axi_wready,
		output logic [1:0]                    s_axi_bresp,
		output logic                          s_axi_bvalid,
		input  logic                          s_axi_bready,
		input  logic [ADDR_WIDTH-1:0]         s_axi_araddr,
		input  logic                          s_axi_arvalid,
		output logic                          s_axi_arready,
		output logic [AXI_DATA_WIDTH-1:0]     s_axi_rdata,
		output logic [1:0]                    s_axi_rresp,
		output logic                          s_axi_rvalid,
		input  logic                          s_axi_rready,

		output logic [WIDTH-1:0]              pad_o,
		output logic [WIDTH-1:0]              pad_t,
		input  logic [WIDTH-1:0]              pad_i
	);

	logic [REG_INDEX_BITS-1:0]   reg_index;
	logic [AXI_DATA_WIDTH-1:0]   reg_wdata;
	logic [AXI_DATA_WIDTH/8-1:0] reg_wstrb;
	logic                        reg_wr;
	logic [AXI_DATA_WIDTH-1:0]   reg_rdata;
	logic [WIDTH-1:0]            manual_drive;
	logic [WIDTH-1:0]            manual_tristate;
	logic                        probe_start;
	logic                        probe_busy;
	logic                        probe_done;
	logic [WIDTH-1:0]            pin_value;
	logic [2*WIDTH-1:0]          pin_class;

	axi_lite_reg_bridge #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_bridge (
		.s_axi_aclk, .rst_n,
		.s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
		.s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
		.s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
		.s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
		.s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
		.reg_index, .reg_wdata, .reg_wstrb, .reg_wr, .reg_rdata
	);

	pin_test_regs #(
		.WIDTH(WIDTH)
	) u_regs (
		.s_axi_aclk, .rst_n,
		.reg_index, .reg_wdata, .reg_wstrb, .reg_wr, .reg_rdata,
		.manual_drive, .manual_tristate, .probe_start,
		.probe_busy, .probe_done, .pin_value, .pin_class
	);

	pin_probe_sequencer #(
		.WIDTH(WIDTH),
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) u_sequencer (
		.s_axi_aclk, .rst_n,
		.manual_drive, .manual_tristate, .probe_start,
		.pad_o, .pad_t, .pad_i,
		.pin_value, .probe_busy, .probe_done, .pin_class
	);

endmodule

//--- verilog/pin_probe_sequencer.sv
module pin_probe_sequencer import pin_test_pkg::*; #(
		parameter int WIDTH         = 8,
		parameter int SETTLE_CYCLES = 16  // At least 3 to cover the sync lag
	) (
		input  logic                 s_axi_aclk,
		input  logic                 rst_n,

		input  logic [WIDTH-1:0]     manual_drive,
		input  logic [WIDTH-1:0]     manual_tristate,
		input  logic                 probe_start,

		// Pads, a set bit in pad_t releases the pin
		output logic [WIDTH-1:0]     pad_o,
		output logic [WIDTH-1:0]     pad_t,
		input  logic [WIDTH-1:0]     pad_i,

		output logic [WIDTH-1:0]     pin_value,
		output logic                 probe_busy,
		output logic                 probe_done,
		output logic [2*WIDTH-1:0]   pin_class
	);

	localparam int CNT_BITS = $clog2(SETTLE_CYCLES);

	probe_state_e        state;
	logic [CNT_BITS-1:0] phase_cnt;
	logic                phase_end;
	logic [WIDTH-1:0]    pad_meta;
	logic [WIDTH-1:0]    pad_sync;
	logic [WIDTH-1:0]    sample0;  // Pins read back after driving 0

	// Two-flop synchronizer on the pad inputs
	always_ff @(posedge s_axi_aclk) begin
		pad_meta <= pad_i;
		pad_sync <= pad_meta;
	end

	assign pin_value  = pad_sync;
	assign probe_busy = (state != PROBE_IDLE);
	assign phase_end  = (phase_cnt == CNT_BITS'(SETTLE_CYCLES - 1));

	always_ff @(posedge s_axi_aclk) begin
		if (!rst_n) begin
			state      <= PROBE_IDLE;
			phase_cnt  <= '0;
			probe_done <= 1'b0;
			pin_class  <= '0;
		end else begin
			if (state == PROBE_IDLE) begin
				if (probe_start) begin
					state      <= PROBE_DRIVE0;
					phase_cnt  <= '0;
					probe_done <= 1'b0;
				end
			end else if (phase_end) begin
				phase_cnt <= '0;
				unique case (state)
					PROBE_DRIVE0: state <= PROBE_HOLD0;
					PROBE_HOLD0:  state <= PROBE_DRIVE1;
					PROBE_DRIVE1: state <= PROBE_HOLD1;
					default: begin  // End of HOLD1
						state      <= PROBE_IDLE;
						probe_done <= 1'b1;
						for (int i = 0; i < WIDTH; i++)
							pin_class[2*i +: 2] <= pin_class_e'({pad_sync[i], sample0[i]});
					end
				endcase
			end else begin
				phase_cnt <= phase_cnt + 1'b1;
			end
		end
	end

	// Keeper value after the 0 drive
	always_ff @(posedge s_axi_aclk) begin
		if (state == PROBE_HOLD0 && phase_end)
			sample0 <= pad_sync;
	end

	// Pad mux, manual registers when idle
	always_comb begin
		unique case (state)
			PROBE_DRIVE0: begin
				pad_o = '0;
				pad_t = '0;
			end
			PROBE_HOLD0: begin
				pad_o = '0;
				pad_t = '1;
			end
			PROBE_DRIVE1: begin
				pad_o = '1;
				pad_t = '0;
			end
			PROBE_HOLD1: begin
				pad_o = '1;
				pad_t = '1;
			end
			default: begin
				pad_o = manual_drive;
				pad_t = manual_tristate;
			end
		endcase
	end

endmodule

//--- verilog/pin_test_regs.sv
module pin_test_regs import pin_test_pkg::*; #(
		parameter int WIDTH = 8
	) (
		input  logic                          s_axi_aclk,
		input  logic                          rst_n,

		input  logic [REG_INDEX_BITS-1:0]     reg_index,
		input  logic [AXI_DATA_WIDTH-1:0]     reg_wdata,
		input  logic [AXI_DATA_WIDTH/8-1:0]   reg_wstrb,
		input  logic                          reg_wr,
		output logic [AXI_DATA_WIDTH-1:0]     reg_rdata,

		// Sequencer side
		output logic [WIDTH-1:0]              manual_drive,
		output logic [WIDTH-1:0]              manual_tristate,
		output logic                          probe_start,
		input  logic                          probe_busy,
		input  logic                          probe_done,
		input  logic [WIDTH-1:0]              pin_value,
		input  logic [2*WIDTH-1:0]            pin_class
	);

	logic [AXI_DATA_WIDTH-1:0] byte_mask;
	logic [WIDTH-1:0]          pin_mask;
	logic                      wr_drive;
	logic                      wr_tristate;
	logic                      wr_start;

	// Expand byte strobes to a per-bit mask
	always_comb begin
		for (int b = 0; b < AXI_DATA_WIDTH / 8; b++)
			byte_mask[8*b +: 8] = {8{reg_wstrb[b]}};
	end

	assign pin_mask    = byte_mask[WIDTH-1:0];
	assign wr_drive    = reg_wr && (reg_index == REG_DRIVE);
	assign wr_tristate = reg_wr && (reg_index == REG_TRISTATE);
	assign wr_start    = reg_wr && (reg_index == REG_CTRL) && reg_wstrb[0] && reg_wdata[0];

	always_ff @(posedge s_axi_aclk) begin
		if (!rst_n) begin
			manual_drive    <= '0;
			manual_tristate <= '1;  // All pins released
			probe_start     <= 1'b0;
		end else begin
			if (wr_drive)
				manual_drive <= (manual_drive & ~pin_mask) | (reg_wdata[WIDTH-1:0] & pin_mask);
			if (wr_tristate)
				manual_tristate <= (manual_tristate & ~pin_mask)
				                   | (reg_wdata[WIDTH-1:0] & pin_mask);
			probe_start <= wr_start;  // Single-cycle pulse
		end
	end

	// Read word, unused bits stay 0
	always_comb begin
		reg_rdata = '0;
		case (reg_index)
			REG_DRIVE:    reg_rdata[WIDTH-1:0]   = manual_drive;
			REG_TRISTATE: reg_rdata[WIDTH-1:0]   = manual_tristate;
			REG_READ:     reg_rdata[WIDTH-1:0]   = pin_value;
			REG_WIDTH:    reg_rdata              = AXI_DATA_WIDTH'(WIDTH);
			REG_STATUS:   reg_rdata[1:0]         = {probe_done, probe_busy};
			REG_CLASS:    reg_rdata[2*WIDTH-1:0] = pin_class;
			default:      reg_rdata              = '0;  // CTRL and unmapped
		endcase
	end

endmodule

//--- verilog/axi_lite_reg_bridge.sv
module axi_lite_reg_bridge import pin_test_pkg::*; #(
		parameter int ADDR_WIDTH = 11
	) (
		input  logic                          s_axi_aclk,
		input  logic                          rst_n,

		// Write address and data
		input  logic [ADDR_WIDTH-1:0]         s_axi_awaddr,
		input  logic                          s_axi_awvalid,
		output logic                          s_axi_awready,
		input  logic [AXI_DATA_WIDTH-1:0]     s_axi_wdata,
		input  logic [AXI_DATA_WIDTH/8-1:0]   s_axi_wstrb,
		input  logic                          s_axi_wvalid,
		output logic                          s_axi_wready,

		// Write response
		output logic [1:0]                    s_axi_bresp,
		output logic                          s_axi_bvalid,
		input  logic                          s_axi_bready,

		// Read address and data
		input  logic [ADDR_WIDTH-1:0]         s_axi_araddr,
		input  logic                          s_axi_arvalid,
		output logic                          s_axi_arready,
		output logic [AXI_DATA_WIDTH-1:0]     s_axi_rdata,
		output logic [1:0]                    s_axi_rresp,
		output logic                          s_axi_rvalid,
		input  logic                          s_axi_rready,

		// Register side
		output logic [REG_INDEX_BITS-1:0]     reg_index,
		output logic [AXI_DATA_WIDTH-1:0]     reg_wdata,
		output logic [AXI_DATA_WIDTH/8-1:0]   reg_wstrb,
		output logic                          reg_wr,
		input  logic [AXI_DATA_WIDTH-1:0]     reg_rdata
	);

	localparam int WORD_BITS = ADDR_WIDTH - 2;

	logic [WORD_BITS-1:0] aw_word;
	logic [WORD_BITS-1:0] ar_word;
	logic                 aw_in_range;
	logic                 ar_in_range;
	logic                 resp_pending;
	logic                 rd_accept;
	logic                 wr_accept;

	// Range is checked on the whole word address so high aliases are rejected
	assign aw_word     = s_axi_awaddr[ADDR_WIDTH-1:2];
	assign ar_word     = s_axi_araddr[ADDR_WIDTH-1:2];
	assign aw_in_range = aw_word < WORD_BITS'(N_REG);
	assign ar_in_range = ar_word < WORD_BITS'(N_REG);

	// One transaction in flight, a held response blocks everything
	assign resp_pending = s_axi_bvalid | s_axi_rvalid;
	assign rd_accept    = s_axi_arvalid & ~resp_pending;
	assign wr_accept    = s_axi_awvalid & s_axi_wvalid & ~resp_pending & ~rd_accept;

	assign s_axi_arready = rd_accept;
	assign s_axi_awready = wr_accept;
	assign s_axi_wready  = wr_accept;

	// Read index wins when a read is taken this cycle
	assign reg_index = rd_accept ? ar_word[REG_INDEX_BITS-1:0]
	                             : aw_word[REG_INDEX_BITS-1:0];
	assign reg_wdata = s_axi_wdata;
	assign reg_wstrb = s_axi_wstrb;
	assign reg_wr    = wr_accept & aw_in_range;  // No strobe for a bad index

	always_ff @(posedge s_axi_aclk) begin
		if (!rst_n) begin
			s_axi_bvalid <= 1'b0;
			s_axi_rvalid <= 1'b0;
		end else begin
			if (wr_accept)
				s_axi_bvalid <= 1'b1;
			else if (s_axi_bready)
				s_axi_bvalid <= 1'b0;

			if (rd_accept)
				s_axi_rvalid <= 1'b1;
			else if (s_axi_rready)
				s_axi_rvalid <= 1'b0;
		end
	end

	// Response payload, held steady while valid waits for ready
	always_ff @(posedge s_axi_aclk) begin
		if (wr_accept)
			s_axi_bresp <= aw_in_range ? RESP_OKAY : RESP_SLVERR;

		if (rd_accept) begin
			if (ar_in_range) begin
				s_axi_rdata <= reg_rdata;
				s_axi_rresp <= RESP_OKAY;
			end else begin
				s_axi_rdata <= '0;  // Nothing behind this address
				s_axi_rresp <= RESP_SLVERR;
			end
		end
	end

endmodule

//--- verilog/pin_test_pkg.sv
package pin_test_pkg;

	localparam int AXI_DATA_WIDTH = 32;
	localparam int REG_INDEX_BITS = 3;  // Word index from address bits 4..2
	localparam int N_REG          = 7;

	// Register map, one 32-bit word per index
	typedef enum logic [REG_INDEX_BITS-1:0] {
		REG_DRIVE    = 3'd0,  // Manual drive value per pin
		REG_TRISTATE = 3'd1,  // Manual release per pin, set bit floats the pin
		REG_READ     = 3'd2,  // Synchronized pad value
		REG_WIDTH    = 3'd3,  // Number of pins
		REG_CTRL     = 3'd4,  // Bit 0 starts a probe
		REG_STATUS   = 3'd5,  // Bit 0 busy, bit 1 done
		REG_CLASS    = 3'd6   // Two bits per pin
	} reg_index_e;

	// Bit 1 is the sample after driving 1, bit 0 the sample after driving 0
	typedef enum logic [1:0] {
		PIN_GND      = 2'd0,
		PIN_CONFLICT = 2'd1,  // Read 1 after 0 and 0 after 1
		PIN_FLOAT    = 2'd2,  // Keeper held whatever was driven
		PIN_VCC      = 2'd3
	} pin_class_e;

	typedef enum logic [2:0] {
		PROBE_IDLE,
		PROBE_DRIVE0,
		PROBE_HOLD0,
		PROBE_DRIVE1,
		PROBE_HOLD1
	} probe_state_e;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
